// ==== Makefile ====
# Verilator build of the ADPCM-A testbench

VERILATOR ?= verilator
TOP       ?= adpcma_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/adpcma_decoder.sv ====
`timescale 1ns/1ps

module adpcma_decoder import adpcma_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cen,
    input  adpcma_nibble_t nibble,
    output adpcma_sample_t sample
);

    // clamp limits of the 12-bit sample
    localparam logic signed [SIG_W-1:0] MAX_POS = {2'b00, {(SIG_W-2){1'b1}}};
    localparam logic signed [SIG_W-1:0] MAX_NEG = {2'b11, {(SIG_W-2){1'b0}}};

    // loop registers, one channel per stage
    logic signed [SIG_W-1:0] x1;
    logic signed [SIG_W-1:0] x2;
    logic signed [SIG_W-1:0] x3;
    logic signed [SIG_W-1:0] x4;
    // one extra bit, sum can exceed the 13-bit range before the clamp
    logic signed [SIG_W:0]   x5;
    logic signed [SIG_W-1:0] x6;
    logic [STEP_W-1:0]       step1;
    logic [STEP_W-1:0]       step2;
    logic [STEP_W-1:0]       step3;
    logic [STEP_W-1:0]       step4;
    logic [STEP_W-1:0]       step5;
    logic [STEP_W-1:0]       step6;
    logic                    sign2;
    logic                    sign3;
    logic                    chon2;
    logic                    chon3;
    logic                    chon4;
    logic [2:0]              ch2;

    // table interface
    logic [STEP_W-1:0]       lut_step;
    logic [2:0]              lut_code;
    logic [11:0]             inc3;
    logic signed [SIG_W-1:0] inc3_ext;
    logic signed [SIG_W-1:0] inc4;

    // stage I helpers
    logic [STEP_W-1:0]       step_cur;
    logic [STEP_W-1:0]       step_next;
    logic [STEP_W-1:0]       step_adapt;

    adpcma_step_lut lut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .step  (lut_step),
        .code  (lut_code),
        .inc   (inc3)
    );

    always_comb begin
        // clr restarts from step 0 before adapting
        step_cur = nibble.clr ? '0 : step1;
        case (nibble.data[2:0])
            3'd4: step_next = step_cur + 6'd2;
            3'd5: step_next = step_cur + 6'd5;
            3'd6: step_next = step_cur + 6'd7;
            3'd7: step_next = step_cur + 6'd9;
            // codes 0..3 step down, floor at 0
            default: step_next = (step_cur == '0) ? '0 : step_cur - 6'd1;
        endcase
        step_adapt = (step_next > 6'(STEP_MAX)) ? 6'(STEP_MAX) : step_next;
        inc3_ext = {1'b0, inc3};
    end

    // stage II output, old accumulator scaled to 16 bits
    always_comb begin
        sample.ch  = ch2;
        sample.pcm = {x2[SIG_W-2:0], {(PCM_W-SIG_W+1){1'b0}}};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x1 <= '0;
            x2 <= '0;
            x3 <= '0;
            x4 <= '0;
            x5 <= '0;
            x6 <= '0;
            step1 <= '0;
            step2 <= '0;
            step3 <= '0;
            step4 <= '0;
            step5 <= '0;
            step6 <= '0;
            sign2 <= 1'b0;
            sign3 <= 1'b0;
            chon2 <= 1'b0;
            chon3 <= 1'b0;
            chon4 <= 1'b0;
            ch2 <= '0;
            lut_step <= '0;
            lut_code <= '0;
            inc4 <= '0;
        end else if (cen) begin
            // I adapt step, address the table
            x2 <= nibble.clr ? '0 : x1;
            step2 <= nibble.chon ? step_adapt : '0;
            sign2 <= nibble.data[3];
            chon2 <= nibble.chon;
            ch2 <= nibble.ch;
            lut_step <= step_cur;
            lut_code <= nibble.data[2:0];
            // II table read in flight
            x3 <= x2;
            step3 <= step2;
            sign3 <= sign2;
            chon3 <= chon2;
            // III negate on sign
            inc4 <= sign3 ? -inc3_ext : inc3_ext;
            x4 <= x3;
            step4 <= step3;
            chon4 <= chon3;
            // IV accumulate, muted channel drops to 0
            if (chon4) begin
                x5 <= x4 + inc4;
            end else begin
                x5 <= '0;
            end
            step5 <= step4;
            // V clamp to 12 bits
            if (x5 > MAX_POS) begin
                x6 <= MAX_POS;
            end else if (x5 < MAX_NEG) begin
                x6 <= MAX_NEG;
            end else begin
                x6 <= x5[SIG_W-1:0];
            end
            step6 <= step5;
            // VI back to the head, same channel's next slot
            x1 <= x6;
            step1 <= step6;
        end
    end

endmodule

// ==== logic/adpcma_level.sv ====
`timescale 1ns/1ps

module adpcma_level import adpcma_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         cen,
    input  logic [2:0]   ch,
    input  adpcma_reg_t  cfg,
    output adpcma_gain_t gain
);

    logic [LEVEL_W-1:0]          level [NUM_CH];
    logic [NUM_CH-1:0]           pan_l;
    logic [NUM_CH-1:0]           pan_r;
    logic [MASTER_W-1:0]         master;

    // lookup for the presented slot
    logic [LEVEL_W-1:0]          cur_level;
    logic                        cur_l;
    logic                        cur_r;
    logic [LEVEL_W+MASTER_W-1:0] prod;

    always_comb begin
        cur_level = '0;
        cur_l = 1'b0;
        cur_r = 1'b0;
        // out of range ch stays silent
        if (ch < 3'(NUM_CH)) begin
            cur_level = level[ch];
            cur_l = pan_l[ch];
            cur_r = pan_r[ch];
        end
        prod = (LEVEL_W+MASTER_W)'(cur_level) * (LEVEL_W+MASTER_W)'(master);
    end

    // register file, written on any cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                level[i] <= '0;
            end
            pan_l <= '0;
            pan_r <= '0;
            master <= '0;
        end else if (cfg.we) begin
            if (cfg.addr < 3'(NUM_CH)) begin
                // pan in the top bits, level at the bottom
                level[cfg.addr] <= cfg.wdata[LEVEL_W-1:0];
                pan_l[cfg.addr] <= cfg.wdata[7];
                pan_r[cfg.addr] <= cfg.wdata[6];
            end else if (cfg.addr == MASTER_ADDR) begin
                master <= cfg.wdata[MASTER_W-1:0];
            end
        end
    end

    // lines up with the decoder output one cen later
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gain <= '0;
        end else if (cen) begin
            gain.ch <= ch;
            gain.gain <= prod[SCALE_SH +: GAIN_W];
            gain.pan_l <= cur_l;
            gain.pan_r <= cur_r;
        end
    end

endmodule

// ==== logic/adpcma_mixer.sv ====
`timescale 1ns/1ps

module adpcma_mixer import adpcma_pkg::*; #(
    parameter int OUT_W = 16
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cen,
    input  adpcma_sample_t sample,
    input  adpcma_gain_t   gain,
    output adpcma_frame_t  frame,
    output logic           frame_valid
);

    // six 17-bit terms need 20 bits, one spare
    localparam int SUM_W = 21;
    localparam int PROD_W = PCM_W + GAIN_W + 1;
    // saturated value widened so the frame takes its top bits
    localparam int EXT_W = (OUT_W > FRAME_W) ? OUT_W : FRAME_W;
    localparam logic signed [SUM_W-1:0] MAX_POS = SUM_W'(2 ** (OUT_W - 1) - 1);
    localparam logic signed [SUM_W-1:0] MIN_NEG = SUM_W'(-(2 ** (OUT_W - 1)));

    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] prod_sh;
    logic signed [SUM_W-1:0]  scaled;
    logic signed [SUM_W-1:0]  add_l;
    logic signed [SUM_W-1:0]  add_r;
    logic signed [SUM_W-1:0]  sum_l;
    logic signed [SUM_W-1:0]  sum_r;
    logic                     last;

    // clamp to OUT_W, then fit the frame field
    function automatic logic signed [FRAME_W-1:0] to_frame(input logic signed [SUM_W-1:0] s);
        logic signed [SUM_W-1:0] c;
        logic signed [EXT_W-1:0] e;
        c = s;
        if (s > MAX_POS) begin
            c = MAX_POS;
        end
        if (s < MIN_NEG) begin
            c = MIN_NEG;
        end
        e = EXT_W'(c);
        return e[EXT_W-1 -: FRAME_W];
    endfunction

    always_comb begin
        // gain is unsigned, zero bit keeps the product signed
        prod = sample.pcm * $signed({1'b0, gain.gain});
        // arithmetic shift rounds toward minus infinity
        prod_sh = prod >>> SCALE_SH;
        scaled = prod_sh[SUM_W-1:0];
        add_l = sum_l + (gain.pan_l ? scaled : '0);
        add_r = sum_r + (gain.pan_r ? scaled : '0);
        last = (sample.ch == 3'(NUM_CH - 1));
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_l <= '0;
            sum_r <= '0;
            frame <= '0;
            frame_valid <= 1'b0;
        end else begin
            // one clk pulse per rotation
            frame_valid <= cen && last;
            if (cen) begin
                if (last) begin
                    frame.left <= to_frame(add_l);
                    frame.right <= to_frame(add_r);
                    // restart for the next rotation
                    sum_l <= '0;
                    sum_r <= '0;
                end else begin
                    sum_l <= add_l;
                    sum_r <= add_r;
                end
            end
        end
    end

endmodule

// ==== logic/adpcma_pkg.sv ====
package adpcma_pkg;

    // channels in the rotation, tied to the decoder depth
    localparam int NUM_CH = 6;

    // accumulator, 12-bit sample plus overflow room
    localparam int SIG_W = 13;
    localparam int STEP_W = 6;
    localparam int STEP_MAX = 48;

    // pcm out of the decoder, accumulator shifted up by 4
    localparam int PCM_W = 16;

    // level widths, linear
    localparam int LEVEL_W = 5;
    localparam int MASTER_W = 6;
    localparam int GAIN_W = 6;
    // divide by 32 after each level product
    localparam int SCALE_SH = 5;

    // frame field width, fixed by the frame struct
    localparam int FRAME_W = 16;

    // register address of the master level
    localparam logic [2:0] MASTER_ADDR = 3'(NUM_CH);

    // one slot of input
    typedef struct packed {
        logic [2:0] ch;
        logic [3:0] data;   // sign in bit 3, magnitude code below
        logic       chon;
        logic       clr;
    } adpcma_nibble_t;

    typedef struct packed {
        logic [2:0]              ch;
        logic signed [PCM_W-1:0] pcm;
    } adpcma_sample_t;

    typedef struct packed {
        logic [2:0]        ch;
        logic [GAIN_W-1:0] gain;
        logic              pan_l;
        logic              pan_r;
    } adpcma_gain_t;

    // addr 0..5 channel, 6 master
    typedef struct packed {
        logic [2:0] addr;
        logic [7:0] wdata;
        logic       we;
    } adpcma_reg_t;

    typedef struct packed {
        logic signed [FRAME_W-1:0] left;
        logic signed [FRAME_W-1:0] right;
    } adpcma_frame_t;

endpackage

// ==== logic/adpcma_step_lut.sv ====
`timescale 1ns/1ps

module adpcma_step_lut (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cen,
    input  logic [5:0]  step,
    input  logic [2:0]  code,
    output logic [11:0] inc
);

    logic [10:0] size;
    logic [14:0] prod;

    always_comb begin
        // adpcm-a step sizes, roughly x1.1 per index
        case (step)
            6'd0: size = 11'd16;
            6'd1: size = 11'd17;
            6'd2: size = 11'd19;
            6'd3: size = 11'd21;
            6'd4: size = 11'd23;
            6'd5: size = 11'd25;
            6'd6: size = 11'd28;
            6'd7: size = 11'd31;
            6'd8: size = 11'd34;
            6'd9: size = 11'd37;
            6'd10: size = 11'd41;
            6'd11: size = 11'd45;
            6'd12: size = 11'd50;
            6'd13: size = 11'd55;
            6'd14: size = 11'd60;
            6'd15: size = 11'd66;
            6'd16: size = 11'd73;
            6'd17: size = 11'd80;
            6'd18: size = 11'd88;
            6'd19: size = 11'd97;
            6'd20: size = 11'd107;
            6'd21: size = 11'd118;
            6'd22: size = 11'd130;
            6'd23: size = 11'd143;
            6'd24: size = 11'd157;
            6'd25: size = 11'd173;
            6'd26: size = 11'd190;
            6'd27: size = 11'd209;
            6'd28: size = 11'd230;
            6'd29: size = 11'd253;
            6'd30: size = 11'd279;
            6'd31: size = 11'd307;
            6'd32: size = 11'd337;
            6'd33: size = 11'd371;
            6'd34: size = 11'd408;
            6'd35: size = 11'd449;
            6'd36: size = 11'd494;
            6'd37: size = 11'd544;
            6'd38: size = 11'd598;
            6'd39: size = 11'd658;
            6'd40: size = 11'd724;
            6'd41: size = 11'd796;
            6'd42: size = 11'd876;
            6'd43: size = 11'd963;
            6'd44: size = 11'd1060;
            6'd45: size = 11'd1166;
            6'd46: size = 11'd1282;
            6'd47: size = 11'd1411;
            6'd48: size = 11'd1552;
            // indices above 48 never reach here
            default: size = '0;
        endcase
        // (2m+1) * size, divided by 8 on the way out
        prod = 15'(size) * 15'({code, 1'b1});
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inc <= '0;
        end else if (cen) begin
            inc <= prod[14:3];
        end
    end

endmodule

// ==== logic/adpcma_top.sv ====
`timescale 1ns/1ps

module adpcma_top import adpcma_pkg::*; #(
    parameter int OUT_W = 16
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           cen,
    input  adpcma_nibble_t nibble,
    input  adpcma_reg_t    cfg,
    output adpcma_frame_t  frame,
    output logic           frame_valid
);

    // decoder and level unit run on the same slot
    adpcma_sample_t sample;
    adpcma_gain_t   gain;

    adpcma_decoder decoder_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen    (cen),
        .nibble (nibble),
        .sample (sample)
    );

    adpcma_level level_i (
        .clk   (clk),
        .rst_n (rst_n),
        .cen   (cen),
        .ch    (nibble.ch),
        .cfg   (cfg),
        .gain  (gain)
    );

    // both results arrive together one cen later
    adpcma_mixer #(
        .OUT_W (OUT_W)
    ) mixer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen),
        .sample      (sample),
        .gain        (gain),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

endmodule

// ==== src.f ====
logic/adpcma_pkg.sv
logic/adpcma_step_lut.sv
logic/adpcma_decoder.sv
logic/adpcma_level.sv
logic/adpcma_mixer.sv
logic/adpcma_top.sv
tests/adpcma_tb.sv

// ==== tests/adpcma_tb.sv ====
`timescale 1ns/1ps

module adpcma_tb import adpcma_pkg::*;;

    localparam int OUT_W = 16;
    localparam int NUM_ROT = 200;
    localparam int MAX_GAP = 3;
    // every slot plus the flush slot, each up to MAX_GAP idle cycles
    localparam int SLOTS = NUM_ROT * NUM_CH + 1;
    localparam int WATCHDOG_NS = SLOTS * (MAX_GAP + 1) * 10 + 2000;

    logic           clk;
    logic           rst_n;
    logic           cen;
    adpcma_nibble_t nibble;
    adpcma_reg_t    cfg;
    adpcma_frame_t  frame;
    logic           frame_valid;

    int seed;
    int errors = 0;
    int frames_seen = 0;
    int frames_exp = 0;

    // adpcm-a step sizes, index 0..48
    int step_size [0:48] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66,
        73, 80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279, 307,
        337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963, 1060, 1166, 1282,
        1411, 1552
    };

    // reference state
    int acc [NUM_CH];
    int stp [NUM_CH];
    int lvl [NUM_CH];
    bit pl [NUM_CH];
    bit pr [NUM_CH];
    int master;
    int sum_l;
    int sum_r;
    adpcma_frame_t exp_q [$];

    adpcma_top #(
        .OUT_W (OUT_W)
    ) dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen         (cen),
        .nibble      (nibble),
        .cfg         (cfg),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic signed [FRAME_W-1:0] saturate(input int s);
        int hi;
        int lo;
        hi = 2 ** (OUT_W - 1) - 1;
        lo = -(2 ** (OUT_W - 1));
        if (s > hi) begin
            s = hi;
        end else if (s < lo) begin
            s = lo;
        end
        return FRAME_W'(s);
    endfunction

    // one slot through decoder, level and mixer rules
    task automatic model_slot(input adpcma_nibble_t n);
        int c;
        int m;
        int old;
        int s;
        int inc;
        int nxt;
        int g;
        int contrib;
        adpcma_frame_t f;
        c = int'(n.ch);
        m = int'(n.data[2:0]);
        old = n.clr ? 0 : acc[c];
        s = n.clr ? 0 : stp[c];
        inc = ((2 * m + 1) * step_size[s]) / 8;
        nxt = n.data[3] ? old - inc : old + inc;
        if (nxt > 2047) begin
            nxt = 2047;
        end else if (nxt < -2048) begin
            nxt = -2048;
        end
        case (m)
            4: s = s + 2;
            5: s = s + 5;
            6: s = s + 7;
            7: s = s + 9;
            default: s = (s > 0) ? s - 1 : 0;
        endcase
        if (s > STEP_MAX) begin
            s = STEP_MAX;
        end
        // muted channel restarts from zero
        if (!n.chon) begin
            nxt = 0;
            s = 0;
        end
        // gain and pan read before any write on this cycle
        g = (lvl[c] * master) / 32;
        contrib = (old * 16 * g) >>> 5;
        if (pl[c]) begin
            sum_l += contrib;
        end
        if (pr[c]) begin
            sum_r += contrib;
        end
        acc[c] = nxt;
        stp[c] = s;
        if (c == NUM_CH - 1) begin
            f.left = saturate(sum_l);
            f.right = saturate(sum_r);
            exp_q.push_back(f);
            frames_exp++;
            sum_l = 0;
            sum_r = 0;
        end
    endtask

    task automatic apply_cfg(input adpcma_reg_t w);
        if (w.we) begin
            if (w.addr < 3'd6) begin
                lvl[w.addr] = int'(w.wdata[4:0]);
                pl[w.addr] = w.wdata[7];
                pr[w.addr] = w.wdata[6];
            end else if (w.addr == 3'd6) begin
                master = int'(w.wdata[5:0]);
            end
        end
    endtask

    function automatic adpcma_nibble_t make_nibble(input int rot, input int ch);
        adpcma_nibble_t n;
        n.ch = 3'(ch);
        n.data = 4'($random(seed));
        n.chon = 1'b1;
        n.clr = 1'b0;
        // long positive runs, then negative runs, then full scale both ways
        if (rot >= 40 && rot < 60) begin
            n.data = 4'h7;
        end else if (rot >= 60 && rot < 80) begin
            n.data = 4'hf;
        end else if (rot >= 140 && rot < 160) begin
            n.data = 4'h7;
        end else if (rot >= 160 && rot < 180) begin
            n.data = 4'hf;
        end
        if (rot >= 80 && rot < 140) begin
            n.chon = (($random(seed) & 7) != 0);
            n.clr = (($random(seed) & 7) == 0);
        end
        return n;
    endfunction

    function automatic adpcma_reg_t make_cfg(input int rot);
        adpcma_reg_t w;
        w = '0;
        if ((rot >= 80 && rot < 140) || rot >= 180) begin
            if (($random(seed) & 3) == 0) begin
                w.we = 1'b1;
                w.addr = 3'($unsigned($random(seed)) % 7);
                w.wdata = 8'($random(seed));
                // master held at 0 in this window
                if (rot >= 120 && rot < 130 && w.addr == 3'd6) begin
                    w.wdata = '0;
                end
            end
        end
        return w;
    endfunction

    // inputs change on the falling edge only
    task automatic drive_cycle(input logic en, input adpcma_nibble_t n, input adpcma_reg_t w);
        @(negedge clk);
        cen = en;
        nibble = n;
        cfg = w;
        if (en) begin
            model_slot(n);
        end
        apply_cfg(w);
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [7:0] wdata);
        adpcma_reg_t w;
        w.addr = addr;
        w.wdata = wdata;
        w.we = 1'b1;
        drive_cycle(1'b0, make_nibble(0, 0), w);
    endtask

    task automatic check_frame(input adpcma_frame_t got, input adpcma_frame_t exp);
        if (got.left !== exp.left) begin
            errors++;
            $display("mismatch at %0t: frame.left got %0d expected %0d",
                     $time, $signed(got.left), $signed(exp.left));
        end
        if (got.right !== exp.right) begin
            errors++;
            $display("mismatch at %0t: frame.right got %0d expected %0d",
                     $time, $signed(got.right), $signed(exp.right));
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            errors++;
            $display("mismatch at %0t: frame_valid count got %0d expected %0d",
                     $time, got, exp);
        end
    endtask

    // frame sampled at the falling edge, well away from the update
    always @(negedge clk) begin
        if (rst_n && frame_valid) begin
            frames_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("frame_valid pulsed at %0t before any rotation was complete", $time);
            end else begin
                check_frame(frame, exp_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int gap;
        adpcma_nibble_t flush;
        seed = 32'h2f71b2af;
        cen = 1'b0;
        nibble = '0;
        cfg = '0;
        rst_n = 1'b0;
        for (int i = 0; i < NUM_CH; i++) begin
            acc[i] = 0;
            stp[i] = 0;
            lvl[i] = 0;
            pl[i] = 1'b0;
            pr[i] = 1'b0;
        end
        master = 0;
        sum_l = 0;
        sum_r = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int rot = 0; rot < NUM_ROT; rot++) begin
            // ch0 alone, gain 31, both sides
            if (rot == 0) begin
                write_reg(3'd0, 8'hdf);
                write_reg(3'd6, 8'd32);
            end
            if (rot == 120) begin
                write_reg(3'd6, 8'd0);
            end
            // all channels full scale for saturation
            if (rot == 140) begin
                for (int c = 0; c < NUM_CH; c++) begin
                    write_reg(3'(c), 8'hdf);
                end
                write_reg(3'd6, 8'd63);
            end
            for (int ch = 0; ch < NUM_CH; ch++) begin
                gap = $unsigned($random(seed)) % (MAX_GAP + 1);
                // stall cycles carry junk the DUT must ignore
                repeat (gap) begin
                    drive_cycle(1'b0, make_nibble(rot, $unsigned($random(seed)) % 8),
                                make_cfg(rot));
                end
                drive_cycle(1'b1, make_nibble(rot, ch), make_cfg(rot));
            end
        end

        // one more cen pushes the last channel-5 item into the mixer
        flush = '0;
        drive_cycle(1'b1, flush, '0);
        for (int i = 0; i < 20 && frames_seen < frames_exp; i++) begin
            drive_cycle(1'b0, flush, '0);
        end
        @(posedge clk);
        check_count(frames_seen, frames_exp);

        $display("errors %0d, frames seen %0d, frames expected %0d",
                 errors, frames_seen, frames_exp);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
